// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  // machine width is fixed to rv32
  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [3:0] alu_op_t;

  localparam xlen_t RESET_PC = '0;
  localparam xlen_t INSN_BYTES = 32'd4;

  // major opcodes
  localparam opcode_t OP_LUI = 7'b0110111;
  localparam opcode_t OP_AUIPC = 7'b0010111;
  localparam opcode_t OP_JAL = 7'b1101111;
  localparam opcode_t OP_JALR = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_REG_IMM = 7'b0010011;
  localparam opcode_t OP_REG_REG = 7'b0110011;
  localparam opcode_t OP_ENVIRON = 7'b1110011;

  // funct3 of the integer groups
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL = 3'b001;
  localparam funct3_t F3_SLT = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR = 3'b100;
  localparam funct3_t F3_SR = 3'b101;
  localparam funct3_t F3_OR = 3'b110;
  localparam funct3_t F3_AND = 3'b111;
  localparam funct3_t F3_JALR = 3'b000;

  // funct3 of the conditional branches
  localparam funct3_t F3_BEQ = 3'b000;
  localparam funct3_t F3_BNE = 3'b001;
  localparam funct3_t F3_BLT = 3'b100;
  localparam funct3_t F3_BGE = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // funct7 selects sub and the arithmetic right shift
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT = 7'b0100000;

  // alu function codes
  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_SLL = 4'd2;
  localparam alu_op_t ALU_SLT = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR = 4'd5;
  localparam alu_op_t ALU_SRL = 4'd6;
  localparam alu_op_t ALU_SRA = 4'd7;
  localparam alu_op_t ALU_OR = 4'd8;
  localparam alu_op_t ALU_AND = 4'd9;
  // second operand straight through for lui
  localparam alu_op_t ALU_PASS_B = 4'd10;

endpackage

`default_nettype wire

// File: rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  rv_pkg::xlen_t    i_insn,
  output rv_pkg::reg_idx_t o_rs1,
  output rv_pkg::reg_idx_t o_rs2,
  output rv_pkg::reg_idx_t o_rd,
  output rv_pkg::xlen_t    o_imm,
  output rv_pkg::alu_op_t  o_alu_op,
  output logic             o_use_imm,
  output logic             o_use_pc,
  output logic             o_is_branch,
  output logic             o_is_jal,
  output logic             o_is_jalr,
  output logic             o_writes_rd,
  output logic             o_is_ecall,
  output rv_pkg::funct3_t  o_funct3
);

  rv_pkg::opcode_t opcode;
  rv_pkg::funct3_t funct3;
  rv_pkg::funct7_t funct7;
  rv_pkg::xlen_t   imm_i;
  rv_pkg::xlen_t   imm_b;
  rv_pkg::xlen_t   imm_j;
  rv_pkg::xlen_t   imm_u;
  rv_pkg::alu_op_t int_op;
  logic            f7_base;
  logic            f7_alt;
  logic            imm_legal;
  logic            reg_legal;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  assign o_rd = i_insn[11:7];
  assign o_rs1 = i_insn[19:15];
  assign o_rs2 = i_insn[24:20];
  assign o_funct3 = funct3;

  // sign-extended immediates
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  assign f7_base = (funct7 == rv_pkg::F7_BASE);
  assign f7_alt = (funct7 == rv_pkg::F7_ALT);

  // one alu code for both the immediate and the register form;
  // sub only exists in the register form
  always_comb begin
    case (funct3)
      rv_pkg::F3_ADD_SUB: begin
        int_op = (f7_alt && opcode == rv_pkg::OP_REG_REG) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      end
      rv_pkg::F3_SLL:  int_op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  int_op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: int_op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  int_op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:   int_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:   int_op = rv_pkg::ALU_OR;
      default:         int_op = rv_pkg::ALU_AND;
    endcase
  end

  // funct7 must be all zero except where it picks sub or sra
  assign imm_legal = (funct3 == rv_pkg::F3_SLL) ? f7_base :
                     (funct3 == rv_pkg::F3_SR)  ? (f7_base || f7_alt) : 1'b1;
  assign reg_legal = (funct3 == rv_pkg::F3_ADD_SUB || funct3 == rv_pkg::F3_SR) ?
                     (f7_base || f7_alt) : f7_base;

  always_comb begin
    o_imm = imm_i;
    o_alu_op = rv_pkg::ALU_ADD;
    o_use_imm = 1'b0;
    o_use_pc = 1'b0;
    o_is_branch = 1'b0;
    o_is_jal = 1'b0;
    o_is_jalr = 1'b0;
    o_writes_rd = 1'b0;
    o_is_ecall = 1'b0;
    case (opcode)
      rv_pkg::OP_LUI: begin
        o_imm = imm_u;
        o_alu_op = rv_pkg::ALU_PASS_B;
        o_use_imm = 1'b1;
        o_writes_rd = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        o_imm = imm_u;
        o_use_imm = 1'b1;
        o_use_pc = 1'b1;
        o_writes_rd = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        o_imm = imm_j;
        o_is_jal = 1'b1;
        o_writes_rd = 1'b1;
      end
      rv_pkg::OP_JALR: begin
        // alu adds rs1 and the offset for the target
        o_use_imm = 1'b1;
        o_is_jalr = (funct3 == rv_pkg::F3_JALR);
        o_writes_rd = (funct3 == rv_pkg::F3_JALR);
      end
      rv_pkg::OP_BRANCH: begin
        o_imm = imm_b;
        o_is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
      end
      rv_pkg::OP_REG_IMM: begin
        o_alu_op = int_op;
        o_use_imm = 1'b1;
        o_writes_rd = imm_legal;
      end
      rv_pkg::OP_REG_REG: begin
        o_alu_op = int_op;
        o_writes_rd = reg_legal;
      end
      rv_pkg::OP_ENVIRON: begin
        o_is_ecall = (i_insn[31:7] == 25'd0);
      end
      default: begin
        // unknown opcode falls through as a plain pc + 4
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire              clk,
  input  wire              rst,
  input  rv_pkg::reg_idx_t i_rs1,
  input  rv_pkg::reg_idx_t i_rs2,
  output rv_pkg::xlen_t    o_rs1_data,
  output rv_pkg::xlen_t    o_rs2_data,
  input  logic             i_we,
  input  rv_pkg::reg_idx_t i_rd,
  input  rv_pkg::xlen_t    i_rd_data
);

  rv_pkg::xlen_t regs [rv_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // x0 is hardwired to zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire              clk,
  input  wire              rst,
  input  rv_pkg::xlen_t    i_rs1_data,
  input  rv_pkg::xlen_t    i_rs2_data,
  input  rv_pkg::xlen_t    i_imm,
  input  rv_pkg::alu_op_t  i_alu_op,
  input  logic             i_use_imm,
  input  logic             i_use_pc,
  input  logic             i_is_branch,
  input  logic             i_is_jal,
  input  logic             i_is_jalr,
  input  logic             i_writes_rd,
  input  logic             i_is_ecall,
  input  rv_pkg::funct3_t  i_funct3,
  input  rv_pkg::reg_idx_t i_rd,
  output rv_pkg::xlen_t    o_pc,
  output logic             o_wb_we,
  output rv_pkg::reg_idx_t o_wb_rd,
  output rv_pkg::xlen_t    o_wb_data,
  output logic             o_halt
);

  rv_pkg::xlen_t pc;
  rv_pkg::xlen_t pc_next;
  rv_pkg::xlen_t pc_plus_4;
  rv_pkg::xlen_t pc_plus_imm;
  rv_pkg::xlen_t op_a;
  rv_pkg::xlen_t op_b;
  rv_pkg::xlen_t alu_result;
  logic [4:0]    shamt;
  logic          cond_true;
  logic          branch_taken;

  // operand muxes
  assign op_a = i_use_pc ? pc : i_rs1_data;
  assign op_b = i_use_imm ? i_imm : i_rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (i_alu_op)
      rv_pkg::ALU_ADD:    alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_result = op_a << shamt;
      rv_pkg::ALU_SLT:    alu_result = rv_pkg::xlen_t'($signed(op_a) < $signed(op_b));
      rv_pkg::ALU_SLTU:   alu_result = rv_pkg::xlen_t'(op_a < op_b);
      rv_pkg::ALU_XOR:    alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:    alu_result = op_a >> shamt;
      rv_pkg::ALU_SRA:    alu_result = rv_pkg::xlen_t'($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:     alu_result = op_a | op_b;
      rv_pkg::ALU_AND:    alu_result = op_a & op_b;
      rv_pkg::ALU_PASS_B: alu_result = op_b;
      default:            alu_result = '0;
    endcase
  end

  // branch comparator always works on the two registers
  always_comb begin
    case (i_funct3)
      rv_pkg::F3_BEQ:  cond_true = (i_rs1_data == i_rs2_data);
      rv_pkg::F3_BNE:  cond_true = (i_rs1_data != i_rs2_data);
      rv_pkg::F3_BLT:  cond_true = ($signed(i_rs1_data) < $signed(i_rs2_data));
      rv_pkg::F3_BGE:  cond_true = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      rv_pkg::F3_BLTU: cond_true = (i_rs1_data < i_rs2_data);
      rv_pkg::F3_BGEU: cond_true = (i_rs1_data >= i_rs2_data);
      default:         cond_true = 1'b0;
    endcase
  end

  assign branch_taken = i_is_branch && cond_true;

  assign pc_plus_4 = pc + rv_pkg::INSN_BYTES;
  assign pc_plus_imm = pc + i_imm;

  // jalr wins, then pc-relative jumps, then fall through
  always_comb begin
    if (i_is_jalr) begin
      pc_next = {alu_result[rv_pkg::XLEN-1:1], 1'b0};
    end else if (i_is_jal || branch_taken) begin
      pc_next = pc_plus_imm;
    end else begin
      pc_next = pc_plus_4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pkg::RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign o_pc = pc;

  // link address for jumps, alu result for everything else
  assign o_wb_data = (i_is_jal || i_is_jalr) ? pc_plus_4 : alu_result;
  assign o_wb_we = i_writes_rd;
  assign o_wb_rd = i_rd;

  // level only for the ecall cycle
  assign o_halt = i_is_ecall;

endmodule

`default_nettype wire

// File: rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire              clk,
  input  wire              rst,
  input  rv_pkg::xlen_t    i_insn,
  output rv_pkg::xlen_t    o_pc,
  output logic             o_wb_valid,
  output rv_pkg::reg_idx_t o_wb_rd,
  output rv_pkg::xlen_t    o_wb_data,
  output logic             o_halt
);

  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::xlen_t    rs1_data;
  rv_pkg::xlen_t    rs2_data;
  rv_pkg::xlen_t    imm;
  rv_pkg::alu_op_t  alu_op;
  rv_pkg::funct3_t  funct3;
  logic             use_imm;
  logic             use_pc;
  logic             is_branch;
  logic             is_jal;
  logic             is_jalr;
  logic             writes_rd;
  logic             is_ecall;

  rv_decode u_decode (
    .i_insn      (i_insn),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_imm       (imm),
    .o_alu_op    (alu_op),
    .o_use_imm   (use_imm),
    .o_use_pc    (use_pc),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr),
    .o_writes_rd (writes_rd),
    .o_is_ecall  (is_ecall),
    .o_funct3    (funct3)
  );

  // write port is also the writeback trace at the top level
  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (o_wb_valid),
    .i_rd       (o_wb_rd),
    .i_rd_data  (o_wb_data)
  );

  rv_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_imm       (imm),
    .i_alu_op    (alu_op),
    .i_use_imm   (use_imm),
    .i_use_pc    (use_pc),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .i_writes_rd (writes_rd),
    .i_is_ecall  (is_ecall),
    .i_funct3    (funct3),
    .i_rd        (rd),
    .o_pc        (o_pc),
    .o_wb_we     (o_wb_valid),
    .o_wb_rd     (o_wb_rd),
    .o_wb_data   (o_wb_data),
    .o_halt      (o_halt)
  );

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic o_clk
);

  // 4 ns period
  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

// File: rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_props (
  input wire           clk,
  input wire           rst,
  input rv_pkg::xlen_t i_pc,
  input logic          i_wb_valid,
  input logic          i_halt
);

  int fail_count = 0;

  // every fetch address sits on a word boundary
  pc_aligned: assert property (@(posedge clk) disable iff (rst) i_pc[1:0] == 2'b00)
    else begin
      $error("pc not word aligned: %h", i_pc);
      fail_count++;
    end

  // first cycle out of reset fetches from zero
  pc_after_reset: assert property (@(posedge clk) $fell(rst) |-> i_pc == '0)
    else begin
      $error("pc not zero after reset: %h", i_pc);
      fail_count++;
    end

  // ecall never writes a register
  halt_without_wb: assert property (@(posedge clk) disable iff (rst) !(i_halt && i_wb_valid))
    else begin
      $error("halt and writeback in the same cycle");
      fail_count++;
    end

endmodule

bind rv_core rv_core_props u_props (
  .clk        (clk),
  .rst        (rst),
  .i_pc       (o_pc),
  .i_wb_valid (o_wb_valid),
  .i_halt     (o_halt)
);

`default_nettype wire

// File: rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int RESET_CYCLES = 5;
  localparam int N_RESET = 32;
  localparam int N_IMM = 80;
  localparam int N_REG = 80;
  localparam int N_BRANCH = 50;
  localparam int N_JUMP = 40;
  localparam int N_SYS = 30;
  localparam int TOTAL_INSNS = N_RESET + N_IMM + N_REG + N_BRANCH + N_JUMP + N_SYS;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_INSNS + 20;
  // addi x0, x0, 0
  localparam rv_pkg::xlen_t NOP = 32'h0000_0013;

  logic             clk;
  logic             rst;
  rv_pkg::xlen_t    insn;
  rv_pkg::xlen_t    pc;
  logic             wb_valid;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::xlen_t    wb_data;
  logic             halt;

  // reference model state
  rv_pkg::xlen_t    model_regs [32];
  rv_pkg::xlen_t    model_pc;
  logic             exp_valid;
  rv_pkg::reg_idx_t exp_rd;
  rv_pkg::xlen_t    exp_data;
  logic             exp_halt;
  rv_pkg::xlen_t    exp_next_pc;

  string test_name;
  int    test_errors = 0;
  int    total_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    cycles = 0;

  tb_clock u_clock (
    .o_clk (clk)
  );

  rv_core DUT (
    .clk        (clk),
    .rst        (rst),
    .i_insn     (insn),
    .o_pc       (pc),
    .o_wb_valid (wb_valid),
    .o_wb_rd    (wb_rd),
    .o_wb_data  (wb_data),
    .o_halt     (halt)
  );

  function automatic rv_pkg::xlen_t ref_alu(logic [2:0] f3, logic alt, rv_pkg::xlen_t a,
                                            rv_pkg::xlen_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? rv_pkg::xlen_t'($signed(a) >>> sh) : a >> sh;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_taken(logic [2:0] f3, rv_pkg::xlen_t a, rv_pkg::xlen_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ISA behavior of one instruction against the model state
  task automatic predict(input rv_pkg::xlen_t ins);
    rv_pkg::xlen_t a;
    rv_pkg::xlen_t b;
    rv_pkg::xlen_t imm_i;
    rv_pkg::xlen_t imm_b;
    rv_pkg::xlen_t imm_j;
    rv_pkg::xlen_t imm_u;
    a = model_regs[ins[19:15]];
    b = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {ins[31:12], 12'd0};
    exp_valid = 1'b0;
    exp_rd = ins[11:7];
    exp_data = '0;
    exp_halt = 1'b0;
    exp_next_pc = model_pc + 32'd4;
    case (ins[6:0])
      7'b0110111: begin
        exp_valid = 1'b1;
        exp_data = imm_u;
      end
      7'b0010111: begin
        exp_valid = 1'b1;
        exp_data = model_pc + imm_u;
      end
      7'b1101111: begin
        exp_valid = 1'b1;
        exp_data = model_pc + 32'd4;
        exp_next_pc = model_pc + imm_j;
      end
      7'b1100111: begin
        exp_valid = 1'b1;
        exp_data = model_pc + 32'd4;
        exp_next_pc = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        if (ref_taken(ins[14:12], a, b)) begin
          exp_next_pc = model_pc + imm_b;
        end
      end
      7'b0010011: begin
        // only srai uses bit 30 in the immediate group
        exp_valid = 1'b1;
        exp_data = ref_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
      end
      7'b0110011: begin
        exp_valid = 1'b1;
        exp_data = ref_alu(ins[14:12], ins[30], a, b);
      end
      7'b1110011: exp_halt = 1'b1;
      default: begin
        // unknown opcode only advances the pc
      end
    endcase
  endtask

  task automatic commit();
    if (exp_valid && exp_rd != 5'd0) begin
      model_regs[exp_rd] = exp_data;
    end
    model_pc = exp_next_pc;
  endtask

  task automatic check_value(input string field, input rv_pkg::xlen_t expected,
                             input rv_pkg::xlen_t actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, field, expected, actual);
      test_errors++;
    end
  endtask

  // drive on the rising edge, compare on the falling edge
  task automatic run_insn(input rv_pkg::xlen_t ins);
    insn <= ins;
    @(negedge clk);
    predict(ins);
    check_value("pc", model_pc, pc);
    check_value("wb_valid", rv_pkg::xlen_t'(exp_valid), rv_pkg::xlen_t'(wb_valid));
    if (exp_valid) begin
      check_value("wb_rd", rv_pkg::xlen_t'(exp_rd), rv_pkg::xlen_t'(wb_rd));
      check_value("wb_data", exp_data, wb_data);
    end
    check_value("halt", rv_pkg::xlen_t'(exp_halt), rv_pkg::xlen_t'(halt));
    commit();
    @(posedge clk);
  endtask

  function automatic rv_pkg::reg_idx_t rand_reg();
    return rv_pkg::reg_idx_t'($urandom_range(31, 0));
  endfunction

  function automatic rv_pkg::xlen_t gen_imm_alu();
    int          kind;
    logic [2:0]  f3;
    logic [11:0] imm;
    kind = int'($urandom_range(9, 0));
    imm = 12'($urandom());
    f3 = 3'($urandom());
    if (kind == 0) begin
      return {20'($urandom()), rand_reg(), 7'b0110111};
    end
    if (kind == 1) begin
      return {20'($urandom()), rand_reg(), 7'b0010111};
    end
    // shift amounts are 5 bits and srai sets bit 30
    if (f3 == 3'b001) begin
      imm = {7'b0000000, imm[4:0]};
    end
    if (f3 == 3'b101) begin
      imm = {1'b0, imm[10], 5'b00000, imm[4:0]};
    end
    return {imm, rand_reg(), f3, rand_reg(), 7'b0010011};
  endfunction

  function automatic rv_pkg::xlen_t gen_reg_reg();
    logic [2:0] f3;
    logic       alt;
    f3 = 3'($urandom());
    alt = (f3 == 3'b000 || f3 == 3'b101) ? 1'($urandom()) : 1'b0;
    return {1'b0, alt, 5'b00000, rand_reg(), rand_reg(), f3, rand_reg(), 7'b0110011};
  endfunction

  function automatic rv_pkg::xlen_t gen_branch();
    logic [2:0]       f3;
    logic [12:0]      off;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    // map 0..5 onto beq bne blt bge bltu bgeu
    f3 = 3'($urandom_range(5, 0));
    if (f3 >= 3'd2) begin
      f3 = f3 + 3'd2;
    end
    off = 13'($urandom()) & 13'h1ffc;
    rs1 = rand_reg();
    rs2 = ($urandom_range(3, 0) == 0) ? rs1 : rand_reg();
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv_pkg::xlen_t gen_jump();
    logic [20:0]      off;
    logic [11:0]      imm;
    logic             odd;
    rv_pkg::reg_idx_t rs1;
    if ($urandom_range(1, 0) == 0) begin
      off = 21'($urandom()) & 21'h1ffffc;
      return {off[20], off[10:1], off[11], off[19:12], rand_reg(), 7'b1101111};
    end
    // target lands on a word and sometimes has bit 0 set before clearing
    rs1 = rand_reg();
    odd = 1'($urandom());
    imm = 12'($urandom());
    imm[1:0] = (2'b00 - model_regs[rs1][1:0]) + {1'b0, odd};
    return {imm, rs1, 3'b000, rand_reg(), 7'b1100111};
  endfunction

  function automatic rv_pkg::xlen_t gen_sys();
    logic [6:0] opc;
    if ($urandom_range(1, 0) == 0) begin
      return 32'h0000_0073;
    end
    opc = 7'($urandom());
    while (opc inside {7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111,
                       7'b1100011, 7'b0010011, 7'b0110011, 7'b1110011}) begin
      opc = 7'($urandom());
    end
    return {25'($urandom()), opc};
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test(input int count);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %-12s %0d instructions, %0d errors, %s", test_name, count, test_errors,
             (test_errors == 0) ? "passed" : "failed");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    insn = NOP;
    model_pc = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    void'($urandom(7));

    // addi xr, xr, 0 reads each cleared register back
    begin_test("reset");
    for (int r = 0; r < N_RESET; r++) begin
      run_insn({12'd0, 5'(r), 3'b000, 5'(r), 7'b0010011});
    end
    end_test(N_RESET);

    begin_test("imm_alu");
    repeat (N_IMM) run_insn(gen_imm_alu());
    end_test(N_IMM);

    begin_test("reg_reg");
    repeat (N_REG) run_insn(gen_reg_reg());
    end_test(N_REG);

    begin_test("branch");
    repeat (N_BRANCH) run_insn(gen_branch());
    end_test(N_BRANCH);

    begin_test("jump");
    repeat (N_JUMP) run_insn(gen_jump());
    end_test(N_JUMP);

    begin_test("ecall_unknown");
    repeat (N_SYS) run_insn(gen_sys());
    end_test(N_SYS);

    $display("tests run %0d, tests failed %0d, checks failed %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors, DUT.u_props.fail_count);
    if (total_errors == 0 && DUT.u_props.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_core.f
rv_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_clock.sv
rv_core_props.sv
rv_core_tb.sv

// File: Makefile
# Verilator build and run of the rv_core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
